// File: io_host_pkg.sv
package io_host_pkg;

  // I/O bus geometry
  localparam int addr_width = 20;
  localparam int data_width = 64;

  // Host register bank sizes
  localparam int num_core = 4;
  localparam int num_trace = 8;
  localparam int core_idx_width = $clog2(num_core);
  localparam int trace_idx_width = $clog2(num_trace);

  // Loader write tracking
  localparam int outstanding_width = 4;

  // Address map, registers are 8 bytes apart
  localparam logic [addr_width-1:0] putchar_addr = 20'h01000;
  localparam logic [addr_width-1:0] finish_base_addr = 20'h02000;
  localparam logic [addr_width-1:0] trace_base_addr = 20'h03000;

  typedef enum logic [0:0]
  {
    mem_rd = 1'b0,
    mem_wr = 1'b1
  } mem_opcode_e;

  typedef enum logic [1:0]
  {
    nbf_write = 2'b00,
    nbf_fence = 2'b01,
    nbf_finish = 2'b10
  } nbf_opcode_e;

  // Bit positions within trace_en_o
  typedef enum logic [trace_idx_width-1:0]
  {
    icache = 3'd0,
    dcache = 3'd1,
    lce = 3'd2,
    cce = 3'd3,
    dram = 3'd4,
    vm = 3'd5,
    cmt = 3'd6,
    core_profile = 3'd7
  } trace_idx_e;

  typedef struct packed
  {
    mem_opcode_e opcode;
    logic [addr_width-1:0] addr;
    logic [data_width-1:0] data;
  } io_cmd_s;

  typedef struct packed
  {
    mem_opcode_e opcode;
    logic [addr_width-1:0] addr;
    logic [data_width-1:0] data;
  } io_resp_s;

  // One boot image record
  typedef struct packed
  {
    nbf_opcode_e opcode;
    logic [addr_width-1:0] addr;
    logic [data_width-1:0] data;
  } nbf_rec_s;

endpackage

// File: resp_fifo.sv
`timescale 1ns/1ps

module resp_fifo
  import io_host_pkg::*;
(
  input  logic     clk_i,
  input  logic     reset_i,

  input  io_resp_s data_i,
  input  logic     v_i,
  output logic     ready_and_o,

  output io_resp_s data_o,
  output logic     v_o,
  input  logic     ready_and_i
);

  io_resp_s mem_r [2];
  logic rptr_r;
  logic wptr_r;
  logic [1:0] count_r;
  logic enq;
  logic deq;

  assign ready_and_o = (count_r != 2'd2);
  assign v_o = (count_r != 2'd0);
  assign data_o = mem_r[rptr_r];

  assign enq = v_i & ready_and_o;
  assign deq = v_o & ready_and_i;

  // Storage only, validity lives in count_r
  always_ff @(posedge clk_i)
  begin
    if (enq)
    begin
      mem_r[wptr_r] <= data_i;
    end
  end

  always_ff @(posedge clk_i)
  begin
    if (reset_i)
    begin
      rptr_r <= 1'b0;
      wptr_r <= 1'b0;
      count_r <= 2'd0;
    end
    else
    begin
      if (enq)
        wptr_r <= ~wptr_r;
      if (deq)
        rptr_r <= ~rptr_r;
      // Simultaneous enq and deq leaves count unchanged
      if (enq & ~deq)
        count_r <= count_r + 2'd1;
      else if (deq & ~enq)
        count_r <= count_r - 2'd1;
    end
  end

endmodule

// File: host_cfg_regs.sv
`timescale 1ns/1ps

module host_cfg_regs
  import io_host_pkg::*;
(
  input  logic                  clk_i,
  input  logic                  reset_i,

  input  logic                  w_v_i,
  input  logic [addr_width-1:0] addr_i,
  input  logic [data_width-1:0] data_i,
  output logic [data_width-1:0] rdata_o,

  output logic [num_trace-1:0]  trace_en_o,
  output logic [num_core-1:0]   finish_o
);

  logic [num_trace-1:0] trace_en_r;
  logic [num_core-1:0] finish_r;

  logic [addr_width-1:0] finish_off;
  logic [addr_width-1:0] trace_off;
  logic finish_hit;
  logic trace_hit;
  logic [core_idx_width-1:0] finish_idx;
  trace_idx_e trace_sel;

  // Offsets into each window, one register per doubleword
  assign finish_off = addr_i - finish_base_addr;
  assign trace_off = addr_i - trace_base_addr;

  assign finish_hit = (finish_off[2:0] == 3'b000)
                    && (finish_off[addr_width-1:3] < num_core);
  assign trace_hit = (trace_off[2:0] == 3'b000)
                   && (trace_off[addr_width-1:3] < num_trace);

  assign finish_idx = finish_off[3 +: core_idx_width];
  assign trace_sel = trace_idx_e'(trace_off[3 +: trace_idx_width]);

  always_ff @(posedge clk_i)
  begin
    if (reset_i)
    begin
      trace_en_r <= '0;
      finish_r <= '0;
    end
    else if (w_v_i)
    begin
      if (finish_hit)
        finish_r[finish_idx] <= data_i[0];
      if (trace_hit)
        trace_en_r[trace_sel] <= data_i[0];
    end
  end

  // Unmapped addresses read as zero
  always_comb
  begin
    rdata_o = '0;
    if (finish_hit)
      rdata_o[0] = finish_r[finish_idx];
    else if (trace_hit)
      rdata_o[0] = trace_en_r[trace_sel];
  end

  assign trace_en_o = trace_en_r;
  assign finish_o = finish_r;

endmodule

// File: io_host_dev.sv
`timescale 1ns/1ps

module io_host_dev
  import io_host_pkg::*;
(
  input  logic                 clk_i,
  input  logic                 reset_i,

  input  io_cmd_s              io_cmd_i,
  input  logic                 io_cmd_v_i,
  output logic                 io_cmd_ready_and_o,

  output io_resp_s             io_resp_o,
  output logic                 io_resp_v_o,
  input  logic                 io_resp_ready_and_i,

  output logic [7:0]           char_o,
  output logic                 char_v_o,
  output logic [num_trace-1:0] trace_en_o,
  output logic [num_core-1:0]  finish_o
);

  logic fifo_ready_lo;
  logic cmd_accept;
  logic cmd_wr;
  logic putchar_wr;
  logic [data_width-1:0] rdata_lo;
  io_resp_s resp_li;
  logic [7:0] char_r;
  logic char_v_r;

  // Commands only stall when the response queue is full
  assign io_cmd_ready_and_o = fifo_ready_lo;
  assign cmd_accept = io_cmd_v_i & fifo_ready_lo;
  assign cmd_wr = cmd_accept & (io_cmd_i.opcode == mem_wr);
  assign putchar_wr = cmd_wr & (io_cmd_i.addr == putchar_addr);

  host_cfg_regs i_cfg_regs
  (
    .clk_i      (clk_i),
    .reset_i    (reset_i),
    .w_v_i      (cmd_wr),
    .addr_i     (io_cmd_i.addr),
    .data_i     (io_cmd_i.data),
    .rdata_o    (rdata_lo),
    .trace_en_o (trace_en_o),
    .finish_o   (finish_o)
  );

  // Write responses carry no data
  always_comb
  begin
    resp_li.opcode = io_cmd_i.opcode;
    resp_li.addr = io_cmd_i.addr;
    if (io_cmd_i.opcode == mem_rd)
      resp_li.data = rdata_lo;
    else
      resp_li.data = '0;
  end

  resp_fifo i_resp_fifo
  (
    .clk_i       (clk_i),
    .reset_i     (reset_i),
    .data_i      (resp_li),
    .v_i         (io_cmd_v_i),
    .ready_and_o (fifo_ready_lo),
    .data_o      (io_resp_o),
    .v_o         (io_resp_v_o),
    .ready_and_i (io_resp_ready_and_i)
  );

  always_ff @(posedge clk_i)
  begin
    if (putchar_wr)
      char_r <= io_cmd_i.data[7:0];
  end

  // Single cycle strobe per character
  always_ff @(posedge clk_i)
  begin
    if (reset_i)
      char_v_r <= 1'b0;
    else
      char_v_r <= putchar_wr;
  end

  assign char_o = char_r;
  assign char_v_o = char_v_r;

endmodule

// File: nbf_loader.sv
`timescale 1ns/1ps

module nbf_loader
  import io_host_pkg::*;
(
  input  logic     clk_i,
  input  logic     reset_i,

  input  nbf_rec_s nbf_i,
  input  logic     nbf_v_i,
  output logic     nbf_ready_and_o,

  output io_cmd_s  load_cmd_o,
  output logic     load_cmd_v_o,
  input  logic     load_cmd_yumi_i,

  input  io_resp_s load_resp_i,
  input  logic     load_resp_v_i,
  output logic     load_resp_ready_and_o,

  output logic     done_o
);

  typedef enum logic [1:0]
  {
    e_idle,
    e_send,
    e_drain,
    e_done
  } state_e;

  state_e state_r;
  io_cmd_s cmd_r;
  logic [outstanding_width-1:0] cnt_r;
  logic finish_pend_r;
  logic cnt_full;
  logic nbf_accept;
  logic cnt_inc;
  logic cnt_dec;

  assign cnt_full = &cnt_r;

  // Only the idle state takes records, and never with a full counter
  assign nbf_ready_and_o = (state_r == e_idle) & ~cnt_full;
  assign nbf_accept = nbf_v_i & nbf_ready_and_o;

  assign load_cmd_o = cmd_r;
  assign load_cmd_v_o = (state_r == e_send);
  assign done_o = (state_r == e_done);

  // Response side is a pure sink
  assign load_resp_ready_and_o = 1'b1;

  assign cnt_inc = load_cmd_yumi_i;
  assign cnt_dec = load_resp_v_i;

  // Write command payload
  always_ff @(posedge clk_i)
  begin
    if (nbf_accept && (nbf_i.opcode == nbf_write))
    begin
      cmd_r.opcode <= mem_wr;
      cmd_r.addr <= nbf_i.addr;
      cmd_r.data <= nbf_i.data;
    end
  end

  always_ff @(posedge clk_i)
  begin
    if (reset_i)
      cnt_r <= '0;
    else if (cnt_inc & ~cnt_dec)
      cnt_r <= cnt_r + 1'b1;
    else if (cnt_dec & ~cnt_inc)
      cnt_r <= cnt_r - 1'b1;
  end

  always_ff @(posedge clk_i)
  begin
    if (reset_i)
    begin
      state_r <= e_idle;
      finish_pend_r <= 1'b0;
    end
    else
    begin
      case (state_r)
        e_idle:
        begin
          if (nbf_accept)
          begin
            case (nbf_i.opcode)
              nbf_write:
                state_r <= e_send;
              nbf_fence:
              begin
                state_r <= e_drain;
                finish_pend_r <= 1'b0;
              end
              nbf_finish:
              begin
                state_r <= e_drain;
                finish_pend_r <= 1'b1;
              end
              // Unknown record types are dropped
              default:
                state_r <= e_idle;
            endcase
          end
        end
        e_send:
        begin
          if (load_cmd_yumi_i)
            state_r <= e_idle;
        end
        e_drain:
        begin
          // No new commands here, so the count only falls
          if (cnt_r == '0)
            state_r <= finish_pend_r ? e_done : e_idle;
        end
        e_done:
          state_r <= e_done;
        default:
          state_r <= e_idle;
      endcase
    end
  end

endmodule

// File: io_host_top.sv
`timescale 1ns/1ps

module io_host_top
  import io_host_pkg::*;
(
  input  logic                 clk_i,
  input  logic                 reset_i,

  input  io_cmd_s              io_cmd_i,
  input  logic                 io_cmd_v_i,
  output logic                 io_cmd_ready_and_o,

  output io_resp_s             io_resp_o,
  output logic                 io_resp_v_o,
  input  logic                 io_resp_ready_and_i,

  input  nbf_rec_s             nbf_i,
  input  logic                 nbf_v_i,
  output logic                 nbf_ready_and_o,

  output io_cmd_s              load_cmd_o,
  output logic                 load_cmd_v_o,
  input  logic                 load_cmd_yumi_i,

  input  io_resp_s             load_resp_i,
  input  logic                 load_resp_v_i,
  output logic                 load_resp_ready_and_o,

  output logic [7:0]           char_o,
  output logic                 char_v_o,
  output logic [num_trace-1:0] trace_en_o,
  output logic [num_core-1:0]  finish_o,
  output logic                 done_o
);

  // Boot image path
  nbf_loader i_nbf_loader
  (
    .clk_i                 (clk_i),
    .reset_i               (reset_i),
    .nbf_i                 (nbf_i),
    .nbf_v_i               (nbf_v_i),
    .nbf_ready_and_o       (nbf_ready_and_o),
    .load_cmd_o            (load_cmd_o),
    .load_cmd_v_o          (load_cmd_v_o),
    .load_cmd_yumi_i       (load_cmd_yumi_i),
    .load_resp_i           (load_resp_i),
    .load_resp_v_i         (load_resp_v_i),
    .load_resp_ready_and_o (load_resp_ready_and_o),
    .done_o                (done_o)
  );

  // Processor MMIO path
  io_host_dev i_host_dev
  (
    .clk_i               (clk_i),
    .reset_i             (reset_i),
    .io_cmd_i            (io_cmd_i),
    .io_cmd_v_i          (io_cmd_v_i),
    .io_cmd_ready_and_o  (io_cmd_ready_and_o),
    .io_resp_o           (io_resp_o),
    .io_resp_v_o         (io_resp_v_o),
    .io_resp_ready_and_i (io_resp_ready_and_i),
    .char_o              (char_o),
    .char_v_o            (char_v_o),
    .trace_en_o          (trace_en_o),
    .finish_o            (finish_o)
  );

endmodule

// File: tb_clock_gen.sv
`timescale 1ns/1ps

module tb_clock_gen
(
  output logic clk_o,
  output logic reset_o
);

  initial
  begin
    clk_o = 1'b0;
    forever
      #2 clk_o = ~clk_o;
  end

  // Released just after the tenth rising edge
  initial
  begin
    reset_o = 1'b1;
    repeat (10) @(posedge clk_o);
    #1 reset_o = 1'b0;
  end

endmodule

// File: tb_io_host.sv
`timescale 1ns/1ps

module tb_io_host
  import io_host_pkg::*;
();

  localparam logic port_proc = 1'b0;
  localparam logic port_nbf = 1'b1;
  localparam int burst = (1 << outstanding_width) / 4;
  // Writes still in flight when the finish record arrives
  localparam int tail_writes = 3;

  typedef struct packed
  {
    logic port;
    logic [2:0] test;
    logic [1:0] opcode;
    logic [addr_width-1:0] addr;
    logic [data_width-1:0] data;
    logic [data_width-1:0] exp_data;
  } step_s;

  logic clk_i;
  logic reset_i;
  io_cmd_s io_cmd_i;
  logic io_cmd_v_i;
  logic io_cmd_ready_and_o;
  io_resp_s io_resp_o;
  logic io_resp_v_o;
  logic io_resp_ready_and_i;
  nbf_rec_s nbf_i;
  logic nbf_v_i;
  logic nbf_ready_and_o;
  io_cmd_s load_cmd_o;
  logic load_cmd_v_o;
  logic load_cmd_yumi_i;
  io_resp_s load_resp_i;
  logic load_resp_v_i;
  logic load_resp_ready_and_o;
  logic [7:0] char_o;
  logic char_v_o;
  logic [num_trace-1:0] trace_en_o;
  logic [num_core-1:0] finish_o;
  logic done_o;

  step_s steps [$];
  io_resp_s exp_resp [$];
  io_cmd_s exp_load [$];
  logic [7:0] exp_chars [$];
  logic [7:0] got_chars [$];
  int resp_gaps [$];
  logic [data_width-1:0] cmd_exp_data;
  logic [num_trace-1:0] exp_trace;
  logic [num_core-1:0] exp_finish;
  int pass_cnt;
  int fail_cnt;
  int fails_at_start;
  int cmd_cnt;
  int resp_cnt;
  int yumi_wait;
  logic fence_pend;
  logic finish_seen;

  tb_clock_gen i_clock_gen
  (
    .clk_o   (clk_i),
    .reset_o (reset_i)
  );

  io_host_top i_dut (.*);

  task automatic check_value(input string name, input logic [data_width-1:0] got,
                             input logic [data_width-1:0] exp);
    if (got !== exp)
    begin
      $display("CHECK FAILED %s got %h expected %h", name, got, exp);
      fail_cnt++;
    end
    else
      pass_cnt++;
  endtask

  function automatic logic [addr_width-1:0] trace_addr(input int k);
    return trace_base_addr + addr_width'(8 * k);
  endfunction

  function automatic logic [addr_width-1:0] finish_addr(input int n);
    return finish_base_addr + addr_width'(8 * n);
  endfunction

  // Bit 0 of the data lands in the addressed register bit
  function automatic void model_write(input logic [addr_width-1:0] addr,
                                      input logic [data_width-1:0] data);
    for (int k = 0; k < num_trace; k++)
      if (addr == trace_addr(k))
        exp_trace[k] = data[0];
    for (int n = 0; n < num_core; n++)
      if (addr == finish_addr(n))
        exp_finish[n] = data[0];
  endfunction

  function automatic void add_proc(input int test, input mem_opcode_e op,
                                   input logic [addr_width-1:0] addr,
                                   input logic [data_width-1:0] data,
                                   input logic [data_width-1:0] exp_data);
    step_s s;
    s.port = port_proc;
    s.test = test[2:0];
    s.opcode = {1'b0, op};
    s.addr = addr;
    s.data = data;
    s.exp_data = exp_data;
    steps.push_back(s);
    if (op == mem_wr && addr == putchar_addr)
      exp_chars.push_back(data[7:0]);
  endfunction

  function automatic void add_nbf(input int test, input nbf_opcode_e op,
                                  input logic [addr_width-1:0] addr,
                                  input logic [data_width-1:0] data);
    step_s s;
    io_cmd_s c;
    s.port = port_nbf;
    s.test = test[2:0];
    s.opcode = op;
    s.addr = addr;
    s.data = data;
    s.exp_data = '0;
    steps.push_back(s);
    if (op == nbf_write)
    begin
      c.opcode = mem_wr;
      c.addr = addr;
      c.data = data;
      exp_load.push_back(c);
    end
  endfunction

  function automatic string test_name(input int t);
    case (t)
      0: return "reset state";
      1: return "trace enables";
      2: return "putchar";
      3: return "finish mask";
      4: return "loader writes";
      default: return "loader done";
    endcase
  endfunction

  task automatic build_table();
    for (int k = 0; k < num_trace; k++)
      add_proc(0, mem_rd, trace_addr(k), '0, '0);
    for (int n = 0; n < num_core; n++)
      add_proc(0, mem_rd, finish_addr(n), '0, '0);
    add_proc(1, mem_wr, trace_addr(icache), 64'h1, '0);
    add_proc(1, mem_rd, trace_addr(icache), '0, 64'h1);
    add_proc(1, mem_wr, trace_addr(cmt), 64'hff, '0);
    add_proc(1, mem_wr, trace_addr(vm), 64'h3, '0);
    add_proc(1, mem_wr, trace_addr(icache), 64'h2, '0);
    add_proc(1, mem_rd, trace_addr(icache), '0, 64'h0);
    add_proc(1, mem_rd, trace_addr(cmt), '0, 64'h1);
    add_proc(1, mem_rd, trace_addr(vm), '0, 64'h1);
    // Upper bytes must not reach char_o
    add_proc(2, mem_wr, putchar_addr, 64'hdead_beef_0000_004f, '0);
    add_proc(2, mem_wr, putchar_addr, 64'h0000_0000_1234_564b, '0);
    add_proc(2, mem_wr, putchar_addr, 64'h0a, '0);
    add_proc(3, mem_wr, finish_addr(0), 64'h1, '0);
    add_proc(3, mem_wr, finish_addr(2), 64'h1, '0);
    add_proc(3, mem_rd, 20'h04000, '0, '0);
    add_proc(3, mem_wr, 20'h04000, 64'h1, '0);
    add_proc(3, mem_wr, finish_addr(1), 64'h5, '0);
    add_proc(3, mem_rd, finish_addr(2), '0, 64'h1);
    add_proc(3, mem_rd, finish_addr(3), '0, 64'h0);
    add_proc(3, mem_rd, finish_base_addr + 20'h4, '0, '0);
    add_proc(3, mem_rd, putchar_addr, '0, '0);
    for (int i = 0; i < burst; i++)
      add_nbf(4, nbf_write, 20'h80000 + addr_width'(8 * i),
              {32'hc0de_0000 + 32'(i), 32'hface_0000 + 32'(i)});
    add_nbf(4, nbf_fence, '0, '0);
    for (int i = 0; i < 3; i++)
      add_nbf(4, nbf_write, 20'h90000 + addr_width'(8 * i), 64'h5a5a_0000_0000_0000 + i);
    // Finish follows these writes before their responses are back
    for (int i = 0; i < tail_writes; i++)
      add_nbf(5, nbf_write, 20'ha0000 + addr_width'(8 * i), 64'h3c3c_0000_0000_0000 + i);
    add_nbf(5, nbf_finish, '0, '0);
  endtask

  task automatic apply_step(input step_s s);
    if (s.port == port_proc)
    begin
      io_cmd_i.opcode = mem_opcode_e'(s.opcode[0]);
      io_cmd_i.addr = s.addr;
      io_cmd_i.data = s.data;
      cmd_exp_data = s.exp_data;
      io_cmd_v_i = 1'b1;
      @(posedge clk_i);
      while (!io_cmd_ready_and_o)
        @(posedge clk_i);
      #1;
      io_cmd_v_i = 1'b0;
    end
    else
    begin
      nbf_i.opcode = nbf_opcode_e'(s.opcode);
      nbf_i.addr = s.addr;
      nbf_i.data = s.data;
      nbf_v_i = 1'b1;
      @(posedge clk_i);
      while (!nbf_ready_and_o)
        @(posedge clk_i);
      #1;
      nbf_v_i = 1'b0;
    end
  endtask

  task automatic finish_test(input int t);
    while (exp_resp.size() != 0 || resp_gaps.size() != 0 || load_cmd_v_o || fence_pend)
    begin
      @(posedge clk_i);
      #1;
    end
    repeat (3) @(posedge clk_i);
    #1;
    if (t == 2)
    begin
      check_value("char count", got_chars.size(), exp_chars.size());
      for (int i = 0; i < exp_chars.size() && i < got_chars.size(); i++)
        check_value("char_o", got_chars[i], exp_chars[i]);
    end
    if (t == 4)
      check_value("unsent load commands", exp_load.size(), tail_writes);
    if (t == 5)
    begin
      while (!done_o)
      begin
        @(posedge clk_i);
        #1;
      end
      // A record offered after done must stay unaccepted
      nbf_i.opcode = nbf_write;
      nbf_v_i = 1'b1;
      repeat (8) @(posedge clk_i);
      #1;
      nbf_v_i = 1'b0;
      check_value("done_o", done_o, 1);
      check_value("nbf_ready_and_o", nbf_ready_and_o, 0);
      check_value("unsent load commands", exp_load.size(), 0);
    end
    $display("test %0d %s finished with %0d errors", t, test_name(t), fail_cnt - fails_at_start);
    fails_at_start = fail_cnt;
  endtask

  initial
  begin
    void'($urandom(32'hcdf25c73));
    io_cmd_i = '0;
    io_cmd_v_i = 1'b0;
    io_resp_ready_and_i = 1'b1;
    nbf_i = '0;
    nbf_v_i = 1'b0;
    load_cmd_yumi_i = 1'b0;
    load_resp_i = '0;
    load_resp_i.opcode = mem_wr;
    load_resp_v_i = 1'b0;
    cmd_exp_data = '0;
    exp_trace = '0;
    exp_finish = '0;
    pass_cnt = 0;
    fail_cnt = 0;
    fails_at_start = 0;
    cmd_cnt = 0;
    resp_cnt = 0;
    yumi_wait = $urandom % 4;
    fence_pend = 1'b0;
    finish_seen = 1'b0;
    build_table();
    @(negedge reset_i);
    check_value("io_resp_v_o", io_resp_v_o, 0);
    check_value("load_cmd_v_o", load_cmd_v_o, 0);
    check_value("char_v_o", char_v_o, 0);
    check_value("done_o", done_o, 0);
    check_value("trace_en_o", trace_en_o, 0);
    check_value("finish_o", finish_o, 0);
    check_value("load_resp_ready_and_o", load_resp_ready_and_o, 1);
    for (int i = 0; i < steps.size(); i++)
    begin
      apply_step(steps[i]);
      if (i == steps.size() - 1 || steps[i + 1].test != steps[i].test)
        finish_test(steps[i].test);
    end
    $display("checks passed %0d, checks failed %0d", pass_cnt, fail_cnt);
    if (fail_cnt == 0)
      $display("TEST PASS");
    else
      $display("TEST FAIL");
    $finish;
  end

  // Response consumer with random back-pressure
  initial
  begin
    io_resp_s exp_r;
    @(negedge reset_i);
    forever
    begin
      @(posedge clk_i);
      check_value("trace_en_o", trace_en_o, exp_trace);
      check_value("finish_o", finish_o, exp_finish);
      if (char_v_o)
        got_chars.push_back(char_o);
      if (io_cmd_v_i && io_cmd_ready_and_o)
      begin
        if (io_cmd_i.opcode == mem_wr)
          model_write(io_cmd_i.addr, io_cmd_i.data);
        exp_r.opcode = io_cmd_i.opcode;
        exp_r.addr = io_cmd_i.addr;
        exp_r.data = cmd_exp_data;
        exp_resp.push_back(exp_r);
      end
      if (io_resp_v_o && io_resp_ready_and_i)
      begin
        if (exp_resp.size() == 0)
        begin
          $display("response arrived with no command outstanding");
          fail_cnt++;
        end
        else
        begin
          exp_r = exp_resp.pop_front();
          check_value("io_resp_o.opcode", io_resp_o.opcode, exp_r.opcode);
          check_value("io_resp_o.addr", io_resp_o.addr, exp_r.addr);
          check_value("io_resp_o.data", io_resp_o.data, exp_r.data);
        end
      end
      #1;
      io_resp_ready_and_i = ($urandom % 4) != 0;
    end
  end

  // Loader yumi and write responses after random gaps
  initial
  begin
    io_cmd_s exp_c;
    @(negedge reset_i);
    forever
    begin
      @(posedge clk_i);
      if (load_resp_v_i)
        resp_cnt++;
      if (load_cmd_v_o && fence_pend)
      begin
        $display("loader issued a command before the fence drained");
        fail_cnt++;
      end
      if (load_cmd_v_o && load_cmd_yumi_i)
      begin
        cmd_cnt++;
        resp_gaps.push_back($urandom % 5);
        yumi_wait = $urandom % 4;
        if (exp_load.size() == 0)
        begin
          $display("loader issued a command that no write record asked for");
          fail_cnt++;
        end
        else
        begin
          exp_c = exp_load.pop_front();
          check_value("load_cmd_o.opcode", load_cmd_o.opcode, exp_c.opcode);
          check_value("load_cmd_o.addr", load_cmd_o.addr, exp_c.addr);
          check_value("load_cmd_o.data", load_cmd_o.data, exp_c.data);
        end
      end
      if (nbf_v_i && nbf_ready_and_o)
      begin
        if (nbf_i.opcode == nbf_fence)
          fence_pend = 1'b1;
        if (nbf_i.opcode == nbf_finish)
          finish_seen = 1'b1;
      end
      if (fence_pend && resp_cnt == cmd_cnt)
        fence_pend = 1'b0;
      if (done_o && !(finish_seen && resp_cnt == cmd_cnt))
      begin
        $display("done_o was high before every loader write was answered");
        fail_cnt++;
      end
      if (done_o && nbf_ready_and_o)
      begin
        $display("loader was ready for records after done");
        fail_cnt++;
      end
      #1;
      load_resp_v_i = 1'b0;
      if (resp_gaps.size() != 0)
      begin
        if (resp_gaps[0] == 0)
        begin
          load_resp_v_i = 1'b1;
          void'(resp_gaps.pop_front());
        end
        else
          resp_gaps[0] = resp_gaps[0] - 1;
      end
      load_cmd_yumi_i = 1'b0;
      if (load_cmd_v_o)
      begin
        if (yumi_wait == 0)
          load_cmd_yumi_i = 1'b1;
        else
          yumi_wait--;
      end
    end
  end

  // Cycle budget scales with the table length
  initial
  begin
    int limit;
    int cycles;
    cycles = 0;
    @(negedge reset_i);
    limit = 40 * steps.size() + 200;
    while (cycles < limit)
    begin
      @(posedge clk_i);
      cycles++;
    end
    $display("run timed out after %0d cycles before the table completed", cycles);
    $display("TEST FAIL");
    $finish;
  end

endmodule

// File: sim.f
io_host_pkg.sv
resp_fifo.sv
host_cfg_regs.sv
io_host_dev.sv
nbf_loader.sv
io_host_top.sv
tb_clock_gen.sv
tb_io_host.sv

// File: Bender.yml
package:
  name: io_host

sources:
  - io_host_pkg.sv
  - resp_fifo.sv
  - host_cfg_regs.sv
  - io_host_dev.sv
  - nbf_loader.sv
  - io_host_top.sv
  - target: simulation
    files:
      - tb_clock_gen.sv
      - tb_io_host.sv
